/* tb.f */
hw/spi_io_pkg.sv
hw/byte_buffer.sv
hw/spi_bit_engine.sv
hw/spi_transfer_ctrl.sv
hw/spi_io_top.sv
bench/spi_slave_model.sv
bench/tb_spi_io.sv

/* Bender.yml */
package:
  name: spi_io

sources:
  - files:
      - hw/spi_io_pkg.sv
      - hw/byte_buffer.sv
      - hw/spi_bit_engine.sv
      - hw/spi_transfer_ctrl.sv
      - hw/spi_io_top.sv
  - target: simulation
    files:
      - bench/spi_slave_model.sv
      - bench/tb_spi_io.sv

/* bench/tb_spi_io.sv */
`timescale 1ns/1ps

module tb_spi_io import spi_io_pkg::*; ();

    logic              sysClk;
    logic              reset;
    buf_req_t          buf_wr;
    xfer_cmd_t         cmd;
    logic [ADDR_W-1:0] rd_addr;
    byte_t             rd_data;
    logic              busy, done, sclk, mosi, cs_n, miso;

    byte_t       tx_mem [BUF_DEPTH];  // What the tx buffer should hold
    byte_t       exp_rx [BUF_DEPTH];  // What the rx buffer should hold
    logic [31:0] lcg_state;
    int          sclk_rises;          // Rising SCLK edges in the current transfer
    int          done_pulses;

    spi_io_top dut0 (
        .sysClk    (sysClk),
        .reset     (reset),
        .buf_wr_i  (buf_wr),
        .cmd_i     (cmd),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .busy_o    (busy),
        .done_o    (done),
        .sclk_o    (sclk),
        .mosi_o    (mosi),
        .cs_n_o    (cs_n),
        .miso_i    (miso)
    );

    spi_slave_model slave0 (
        .sclk_i (sclk),
        .cs_n_i (cs_n),
        .mosi_i (mosi),
        .miso_o (miso)
    );

    initial begin
        sysClk = 1'b0;
        forever #10 sysClk = ~sysClk;  // 20 ns period
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_val(input string test, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: expected %0h, actual %0h", test, exp, act));
        end
    endtask

    function automatic byte_t lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];  // Middle bits spread better than the low ones
    endfunction

    task automatic write_tx(input int addr, input byte_t data);
        buf_wr.addr  = ADDR_W'(addr);
        buf_wr.we    = 1'b1;
        buf_wr.re    = 1'b0;
        buf_wr.wdata = data;
        @(negedge sysClk);
        buf_wr = '0;
    endtask

    task automatic fill_tx(input int n);  // Fresh LCG data into buffer and model
        for (int i = 0; i < n; i++) begin
            tx_mem[i] = lcg_byte();
            write_tx(i, tx_mem[i]);
        end
    endtask

    task automatic read_rx(input int addr, output byte_t data);
        rd_addr = ADDR_W'(addr);
        @(negedge sysClk);  // Registered read
        data = rd_data;
    endtask

    task automatic compare_rx(input string test, input int count);
        byte_t got;
        for (int i = 0; i < count; i++) begin
            read_rx(i, got);
            check_val($sformatf("%s rx[%0d]", test, i), exp_rx[i], got);
        end
    endtask

    task automatic start_xfer(input logic [LEN_W-1:0] len);
        sclk_rises  = 0;
        done_pulses = 0;
        cmd.valid   = 1'b1;
        cmd.len     = len;
        @(negedge sysClk);
        cmd = '0;
        check_val("busy after start", 1, busy);
    endtask

    task automatic finish_xfer(input string test, input int n_eff);
        while (!done) @(negedge sysClk);
        repeat (4) @(negedge sysClk);  // Room for a stray second pulse
        check_val({test, " done pulses"}, 1, done_pulses);
        check_val({test, " busy at end"}, 0, busy);
        check_val({test, " sclk rises"}, 8 * n_eff, sclk_rises);
        exp_rx[0] = 8'hA5;                  // Slave answers A5 first
        for (int i = 1; i < n_eff; i++) begin
            exp_rx[i] = tx_mem[i - 1];      // Then echoes the previous byte
        end
    endtask

    // --------------------
    // Monitors
    // --------------------
    always @(posedge sclk) sclk_rises = sclk_rises + 1;

    always @(negedge sysClk) begin
        if (done) done_pulses = done_pulses + 1;
        if (reset) check_val("cs_n against busy", !busy, cs_n);  // Low exactly while busy
    end

    // Budget of 80 cycles per byte over 1+16+3+7+4+1+16 bytes plus slack
    initial begin
        repeat ((1 + 16 + 3 + 7 + 4 + 1 + 16) * 80 + 2000) @(posedge sysClk);
        stop_run("Watchdog expired, the transfer never completed");
    end

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_idle();
        repeat (5) @(negedge sysClk);
        check_val("idle cs_n", 1, cs_n);
        check_val("idle sclk", 0, sclk);
        check_val("idle mosi", 0, mosi);
        check_val("idle busy", 0, busy);
        check_val("idle done", 0, done);
    endtask

    task automatic test_single();
        fill_tx(1);
        start_xfer(LEN_W'(1));
        finish_xfer("single", 1);
        compare_rx("single", 1);
    endtask

    task automatic test_full();
        fill_tx(16);
        start_xfer(LEN_W'(16));
        finish_xfer("full", 16);
        compare_rx("full", BUF_DEPTH);
    endtask

    task automatic test_back_to_back();
        fill_tx(3);
        start_xfer(LEN_W'(3));
        finish_xfer("len3", 3);
        compare_rx("len3", BUF_DEPTH);  // Entries 3..15 keep earlier data
        fill_tx(7);
        start_xfer(LEN_W'(7));
        finish_xfer("len7", 7);
        compare_rx("len7", BUF_DEPTH);
    endtask

    task automatic test_busy_ignore();
        fill_tx(4);
        start_xfer(LEN_W'(4));
        cmd.valid = 1'b1;               // Second start while busy
        cmd.len   = LEN_W'(16);
        @(negedge sysClk);
        cmd = '0;
        for (int i = 0; i < 4; i++) begin
            write_tx(i, lcg_byte());    // Dropped by the lockout
        end
        finish_xfer("busy", 4);
        compare_rx("busy", BUF_DEPTH);
    endtask

    task automatic test_clamp();
        fill_tx(1);
        start_xfer(LEN_W'(0));
        finish_xfer("len0", 1);
        compare_rx("len0", BUF_DEPTH);
        fill_tx(16);
        start_xfer(LEN_W'(20));
        finish_xfer("len20", 16);
        compare_rx("len20", BUF_DEPTH);
    endtask

    initial begin
        lcg_state   = 32'h02070b7b;
        reset       = 1'b0;
        buf_wr      = '0;
        cmd         = '0;
        rd_addr     = '0;
        sclk_rises  = 0;
        done_pulses = 0;
        repeat (10) @(negedge sysClk);
        reset = 1'b1;
        test_reset_idle();
        test_single();
        test_full();
        test_back_to_back();
        test_busy_ignore();
        test_clamp();
        $display("All tests passed");
        $finish;
    end

endmodule

/* bench/spi_slave_model.sv */
`timescale 1ns/1ps

// Mode 0 SPI slave
// Answers each byte with the byte it received before, 8'hA5 first
module spi_slave_model import spi_io_pkg::*; (
    input  logic sclk_i,
    input  logic cs_n_i,
    input  logic mosi_i,
    output logic miso_o
);

    byte_t tx_sh;    // Byte going out on MISO
    byte_t rx_sh;    // Byte coming in on MOSI
    int    bit_cnt;  // Bits received in the current byte

    assign miso_o = tx_sh[7];  // MSB first

    initial begin
        tx_sh   = 8'hA5;
        rx_sh   = '0;
        bit_cnt = 0;
    end

    // Fresh start with every select
    always @(negedge cs_n_i) begin
        tx_sh   = 8'hA5;
        bit_cnt = 0;
    end

    always @(posedge sclk_i) begin
        if (!cs_n_i) begin
            rx_sh   = {rx_sh[6:0], mosi_i};  // Sample on rising edge
            bit_cnt = bit_cnt + 1;
        end
    end

    // --------------------
    // Shift out on the falling edge
    // --------------------
    always @(negedge sclk_i) begin
        if (!cs_n_i) begin
            if (bit_cnt == 8) begin
                tx_sh   = rx_sh;  // Echo of the byte just received
                bit_cnt = 0;
            end else begin
                tx_sh = {tx_sh[6:0], 1'b0};
            end
        end
    end

endmodule

/* hw/spi_io_top.sv */
`timescale 1ns/1ps

// SPI master I/O block
// Host fills tx buffer, starts a transfer, reads rx buffer
module spi_io_top import spi_io_pkg::*; (
    input  logic              sysClk,
    input  logic              reset,      // Synchronous, active low
    input  buf_req_t          buf_wr_i,   // Host access to tx buffer
    input  xfer_cmd_t         cmd_i,      // Start command
    input  logic [ADDR_W-1:0] rd_addr_i,  // Host rx buffer address
    output byte_t             rd_data_o,  // One cycle after rd_addr_i
    output logic              busy_o,
    output logic              done_o,
    output logic              sclk_o,
    output logic              mosi_o,
    output logic              cs_n_o,
    input  logic              miso_i
);

    buf_req_t ctrl_tx_req;   // Controller side requests
    buf_req_t ctrl_rx_req;
    buf_req_t host_rd_req;
    buf_req_t tx_req;        // Requests seen by the buffers
    buf_req_t rx_req;
    byte_t    tx_data;
    byte_t    tx_byte;
    byte_t    rx_byte;
    logic     byte_go;
    logic     byte_done;

    // --------------------
    // Buffer muxing
    // --------------------
    always_comb begin
        host_rd_req      = '0;
        host_rd_req.addr = rd_addr_i;
        host_rd_req.re   = 1'b1;
    end

    assign tx_req = busy_o ? ctrl_tx_req : buf_wr_i;          // Host locked out while busy
    assign rx_req = ctrl_rx_req.we ? ctrl_rx_req : host_rd_req;

    byte_buffer tx_buf0 (
        .sysClk    (sysClk),
        .req_i     (tx_req),
        .rd_data_o (tx_data)
    );

    byte_buffer rx_buf0 (
        .sysClk    (sysClk),
        .req_i     (rx_req),
        .rd_data_o (rd_data_o)
    );

    // --------------------
    // Controller and engine
    // --------------------
    spi_transfer_ctrl ctrl0 (
        .sysClk      (sysClk),
        .reset       (reset),
        .cmd_i       (cmd_i),
        .tx_req_o    (ctrl_tx_req),
        .tx_data_i   (tx_data),
        .rx_req_o    (ctrl_rx_req),
        .byte_go_o   (byte_go),
        .tx_byte_o   (tx_byte),
        .byte_done_i (byte_done),
        .rx_byte_i   (rx_byte),
        .cs_n_o      (cs_n_o),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    spi_bit_engine engine0 (
        .sysClk      (sysClk),
        .reset       (reset),
        .byte_go_i   (byte_go),
        .tx_byte_i   (tx_byte),
        .byte_done_o (byte_done),
        .rx_byte_o   (rx_byte),
        .shifting_o  (),
        .sclk_o      (sclk_o),
        .mosi_o      (mosi_o),
        .miso_i      (miso_i)
    );

endmodule

/* hw/spi_transfer_ctrl.sv */
`timescale 1ns/1ps

// Sequences one transfer of 1..16 bytes
// Reads tx byte i, runs it through the bit engine, writes rx byte i
module spi_transfer_ctrl import spi_io_pkg::*; (
    input  logic      sysClk,
    input  logic      reset,        // Synchronous, active low
    input  xfer_cmd_t cmd_i,        // Start request from host
    output buf_req_t  tx_req_o,     // Transmit buffer access
    input  byte_t     tx_data_i,    // Transmit buffer read data
    output buf_req_t  rx_req_o,     // Receive buffer access
    output logic      byte_go_o,    // Start one byte in the engine
    output byte_t     tx_byte_o,
    input  logic      byte_done_i,  // Engine finished a byte
    input  byte_t     rx_byte_i,    // Byte received by the engine
    output logic      cs_n_o,
    output logic      busy_o,       // Set with select and cleared with deselect
    output logic      done_o        // One cycle pulse after deselect
);

    ctrl_state_e       state_q;
    logic [ADDR_W-1:0] idx_q;        // Current byte index
    logic [ADDR_W-1:0] last_q;       // Index of final byte
    logic              issued_q;     // byte_go already sent for this byte
    logic [LEN_W-1:0]  len_clamped;
    logic              accept;

    // --------------------
    // Length clamp
    // --------------------
    always_comb begin
        len_clamped = cmd_i.len;
        if (cmd_i.len == '0) begin
            len_clamped = LEN_W'(1);  // Zero length runs one byte
        end else if (cmd_i.len > LEN_W'(BUF_DEPTH)) begin
            len_clamped = LEN_W'(BUF_DEPTH);
        end
    end

    assign accept = (state_q == CTRL_IDLE) && cmd_i.valid;  // Ignored unless idle

    // Both buffers use the current byte index
    always_comb begin
        tx_req_o      = '0;
        tx_req_o.addr = idx_q;
        tx_req_o.re   = (state_q == CTRL_LOAD);
        rx_req_o       = '0;
        rx_req_o.addr  = idx_q;
        rx_req_o.we    = (state_q == CTRL_STORE);
        rx_req_o.wdata = rx_byte_i;  // Engine holds it until the next byte
    end

    assign byte_go_o = (state_q == CTRL_SHIFT) && !issued_q;
    assign tx_byte_o = tx_data_i;  // Read data lands on the first SHIFT cycle

    // --------------------
    // State machine
    // --------------------
    always_ff @(posedge sysClk) begin
        if (!reset) begin
            state_q  <= CTRL_IDLE;
            cs_n_o   <= 1'b1;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
            issued_q <= 1'b0;
            idx_q    <= '0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                CTRL_IDLE: begin
                    if (accept) begin
                        cs_n_o  <= 1'b0;  // Select one cycle after the command
                        busy_o  <= 1'b1;
                        idx_q   <= '0;
                        state_q <= CTRL_SELECT;
                    end
                end
                CTRL_SELECT: begin
                    state_q <= CTRL_LOAD;  // Extra setup before first SCLK
                end
                CTRL_LOAD: begin
                    issued_q <= 1'b0;
                    state_q  <= CTRL_SHIFT;
                end
                CTRL_SHIFT: begin
                    if (byte_go_o) begin
                        issued_q <= 1'b1;
                    end
                    if (byte_done_i) begin
                        state_q <= CTRL_STORE;
                    end
                end
                CTRL_STORE: begin
                    if (idx_q == last_q) begin
                        cs_n_o  <= 1'b1;
                        busy_o  <= 1'b0;
                        state_q <= CTRL_DESELECT;
                    end else begin
                        idx_q   <= idx_q + ADDR_W'(1);
                        state_q <= CTRL_LOAD;
                    end
                end
                CTRL_DESELECT: begin
                    done_o  <= 1'b1;
                    state_q <= CTRL_IDLE;
                end
                default: state_q <= CTRL_IDLE;
            endcase
        end
    end

    // Last index captured with the command
    always_ff @(posedge sysClk) begin
        if (accept) begin
            last_q <= ADDR_W'(len_clamped - LEN_W'(1));
        end
    end

endmodule

/* hw/spi_bit_engine.sv */
`timescale 1ns/1ps

// Mode 0 bit engine
// One byte per byte_go_i, MSB first, full duplex
// SCLK only runs while a byte is in flight
module spi_bit_engine import spi_io_pkg::*; (
    input  logic  sysClk,
    input  logic  reset,        // Synchronous, active low
    input  logic  byte_go_i,    // Start one byte, taken only when idle
    input  byte_t tx_byte_i,    // Byte to send
    output logic  byte_done_o,  // One cycle pulse, rx_byte_o valid
    output byte_t rx_byte_o,    // Byte sampled from MISO
    output logic  shifting_o,   // High while the byte is on the wire
    output logic  sclk_o,
    output logic  mosi_o,
    input  logic  miso_i
);

    logic [HALF_W-1:0] half_cnt_q;  // Position in current half period
    logic [2:0]        bit_cnt_q;   // Bits completed
    byte_t             tx_sh_q;     // Outgoing shift register
    byte_t             rx_sh_q;     // Incoming shift register
    logic              half_end;    // Last cycle of a half period
    logic              start;
    logic              rise;        // SCLK goes high this cycle
    logic              fall;        // SCLK goes low this cycle
    logic              last_fall;   // Falling edge of bit 7

    assign half_end  = shifting_o && (half_cnt_q == HALF_W'(SCLK_HALF - 1));
    assign start     = byte_go_i && !shifting_o;
    assign rise      = half_end && !sclk_o;
    assign fall      = half_end && sclk_o;
    assign last_fall = fall && (bit_cnt_q == 3'd7);

    // --------------------
    // Control and pins
    // --------------------
    always_ff @(posedge sysClk) begin
        if (!reset) begin
            shifting_o  <= 1'b0;
            byte_done_o <= 1'b0;
            sclk_o      <= 1'b0;
            mosi_o      <= 1'b0;
            half_cnt_q  <= '0;
            bit_cnt_q   <= '0;
        end else begin
            byte_done_o <= 1'b0;  // Default, pulse only
            if (start) begin
                shifting_o <= 1'b1;
                half_cnt_q <= '0;
                bit_cnt_q  <= '0;
                mosi_o     <= tx_byte_i[7];  // First bit ahead of first rising edge
            end else if (shifting_o) begin
                if (half_end) begin
                    half_cnt_q <= '0;
                    sclk_o     <= ~sclk_o;
                end else begin
                    half_cnt_q <= half_cnt_q + HALF_W'(1);
                end
                // Next bit goes out on the falling edge
                if (fall) begin
                    bit_cnt_q <= bit_cnt_q + 3'd1;
                    mosi_o    <= tx_sh_q[6];
                end
                if (last_fall) begin
                    shifting_o  <= 1'b0;
                    byte_done_o <= 1'b1;
                    mosi_o      <= 1'b0;  // Idle low between bytes
                end
            end
        end
    end

    // --------------------
    // Data path
    // --------------------
    always_ff @(posedge sysClk) begin
        if (start) begin
            tx_sh_q <= tx_byte_i;
        end else if (fall) begin
            tx_sh_q <= {tx_sh_q[6:0], 1'b0};
        end
        if (rise) begin
            rx_sh_q <= {rx_sh_q[6:0], miso_i};  // Sample on rising edge
        end
        if (last_fall) begin
            rx_byte_o <= rx_sh_q;  // All 8 bits in after the 8th rise
        end
    end

endmodule

/* hw/byte_buffer.sv */
`timescale 1ns/1ps

// Byte memory with one access port and a registered read
module byte_buffer import spi_io_pkg::*; (
    input  logic     sysClk,
    input  buf_req_t req_i,      // Address, enables and write data
    output byte_t    rd_data_o   // Valid the cycle after req_i.re
);

    byte_t mem [BUF_DEPTH];  // Storage

    // --------------------
    // Write and read port
    // --------------------
    always_ff @(posedge sysClk) begin
        if (req_i.we) begin
            mem[req_i.addr] <= req_i.wdata;
        end
        // Old read data is kept when re is low
        if (req_i.re) begin
            rd_data_o <= mem[req_i.addr];
        end
    end

endmodule

/* hw/spi_io_pkg.sv */
package spi_io_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int BUF_DEPTH = 16;  // Bytes per buffer
    localparam int ADDR_W    = 4;   // Buffer address width
    localparam int LEN_W     = 5;   // Holds transfer length 1..16

    // --------------------
    // SPI timing
    // --------------------
    localparam int SCLK_HALF = 4;                  // sysClk cycles per SCLK half period
    localparam int HALF_W    = $clog2(SCLK_HALF);  // Half period counter width

    typedef logic [7:0] byte_t;

    // Start command from the host
    typedef struct packed {
        logic             valid;  // Start request
        logic [LEN_W-1:0] len;    // Bytes to exchange, clamped to 1..16
    } xfer_cmd_t;

    // One buffer access, shared by host and controller
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;     // Write enable
        logic              re;     // Read enable, data one cycle later
        byte_t             wdata;
    } buf_req_t;

    // Transfer controller states
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_SELECT,    // Chip select setup
        CTRL_LOAD,      // Read tx byte from buffer
        CTRL_SHIFT,     // Bit engine busy with one byte
        CTRL_STORE,     // Write rx byte to buffer
        CTRL_DESELECT   // Chip select released, done pulse
    } ctrl_state_e;

endpackage
